//--- src/bf_pkg.sv
package bf_pkg;

   // bucket geometry of one SRAM record
   localparam int bucket_bits  = 4;
   localparam int num_buckets  = 12;
   localparam int record_width = bucket_bits * num_buckets;  // 48

   localparam int hash_width   = 19;

   typedef logic [bucket_bits-1:0]  bucket_t;
   typedef logic [record_width-1:0] record_t;  // bucket 11 in the top nibble
   typedef logic [hash_width-1:0]   hash_t;

   typedef enum logic {
      ev_data = 1'b0,  // increment bucket 11
      ev_ack  = 1'b1   // decrement highest nonzero bucket
   } event_kind_t;

   // event as it enters the design and sits in the FIFO, 39 bits
   typedef struct packed {
      event_kind_t kind;
      hash_t       hash0;
      hash_t       hash1;
   } bf_event_t;

   typedef enum logic [2:0] {
      st_idle,    // wait for an event
      st_read,    // read strobe out
      st_wait,    // wait for rd_vld
      st_update,  // record through bucket_update
      st_write    // write strobe out
   } seq_state_t;

endpackage

//--- src/event_queue.sv
module event_queue #(
   parameter int DEPTH_BITS = 3
) (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              push,
   input  bf_pkg::bf_event_t push_ev,
   input  logic              pop,
   output bf_pkg::bf_event_t head_ev,
   output logic              not_empty,
   output logic              full
);

   localparam int depth = 1 << DEPTH_BITS;

   bf_pkg::bf_event_t     mem [depth];
   logic [DEPTH_BITS-1:0] wr_ptr;
   logic [DEPTH_BITS-1:0] rd_ptr;
   logic [DEPTH_BITS:0]   count;   // one extra bit so that depth fits
   logic                  do_push;
   logic                  do_pop;

   // a push while full is dropped
   assign do_push = push && !full;
   assign do_pop  = pop && not_empty;

   // storage
   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr] <= push_ev;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
         end
         if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;  // none, or push and pop together
         endcase
      end
   end

   // fall-through head, valid the cycle after the push edge
   assign head_ev   = mem[rd_ptr];
   assign not_empty = (count != '0);

   // count never exceeds depth, so the msb alone marks full
   assign full      = count[DEPTH_BITS];

endmodule

//--- src/bucket_update.sv
module bucket_update (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                update_go,
   input  bf_pkg::event_kind_t kind,
   input  bf_pkg::record_t     rec_in,
   output bf_pkg::record_t     rec_out
);

   localparam int top_lsb = (bf_pkg::num_buckets - 1) * bf_pkg::bucket_bits;

   bf_pkg::record_t rec_next;

   // next record, combinational
   always_comb begin
      bf_pkg::bucket_t cur;
      logic            hit;

      rec_next = rec_in;
      hit      = 1'b0;

      if (kind == bf_pkg::ev_data) begin
         cur = rec_in[top_lsb +: bf_pkg::bucket_bits];
         if (cur != '1) begin  // saturate at 15
            rec_next[top_lsb +: bf_pkg::bucket_bits] = cur + 1'b1;
         end
      end else begin
         cur = '0;
         // priority search from bucket 11 down
         for (int i = bf_pkg::num_buckets - 1; i >= 0; i--) begin
            if (!hit && rec_in[i*bf_pkg::bucket_bits +: bf_pkg::bucket_bits] != '0) begin
               cur = rec_in[i*bf_pkg::bucket_bits +: bf_pkg::bucket_bits];
               rec_next[i*bf_pkg::bucket_bits +: bf_pkg::bucket_bits] = cur - 1'b1;
               hit = 1'b1;
            end
         end
         // all-zero record falls out unchanged
      end
   end

   // result valid one cycle after update_go
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rec_out <= '0;
      end else if (update_go) begin
         rec_out <= rec_next;
      end
   end

endmodule

//--- src/bucket_sequencer.sv
module bucket_sequencer #(
   parameter int ADDR_WIDTH = 19
) (
   input  logic                  clk,
   input  logic                  rst_n,

   // event queue side
   input  bf_pkg::bf_event_t     head_ev,
   input  logic                  not_empty,
   output logic                  pop,

   // SRAM read port
   output logic                  rd_req,
   output logic [ADDR_WIDTH-1:0] rd_addr,
   input  bf_pkg::record_t       rd_data,
   input  logic                  rd_vld,

   // SRAM write port
   output logic                  wr_req,
   output logic [ADDR_WIDTH-1:0] wr_addr,
   output bf_pkg::record_t       wr_data
);

   bf_pkg::seq_state_t    state;
   logic                  pass;      // 0 hash0 pass, 1 hash1 pass
   bf_pkg::bf_event_t     ev_q;      // event in flight
   logic [ADDR_WIDTH-1:0] cur_addr;  // record of the current pass
   bf_pkg::record_t       rec_q;     // captured read data
   bf_pkg::record_t       rec_new;   // updated record
   logic                  update_go;

   // take the head as soon as we are idle
   assign pop = (state == bf_pkg::st_idle) && not_empty;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= bf_pkg::st_idle;
         pass  <= 1'b0;
      end else begin
         case (state)
            bf_pkg::st_idle: begin
               if (pop) begin
                  pass  <= 1'b0;
                  state <= bf_pkg::st_read;
               end
            end
            bf_pkg::st_read: begin
               state <= bf_pkg::st_wait;  // one read outstanding
            end
            bf_pkg::st_wait: begin
               if (rd_vld) begin
                  state <= bf_pkg::st_update;
               end
            end
            bf_pkg::st_update: begin
               state <= bf_pkg::st_write;
            end
            bf_pkg::st_write: begin
               if (!pass) begin
                  // second pass reads what this write left behind
                  pass  <= 1'b1;
                  state <= bf_pkg::st_read;
               end else begin
                  pass  <= 1'b0;
                  state <= bf_pkg::st_idle;
               end
            end
            default: begin
               state <= bf_pkg::st_idle;
            end
         endcase
      end
   end

   // event, address and read data registers
   always_ff @(posedge clk) begin
      if (pop) begin
         ev_q     <= head_ev;
         cur_addr <= head_ev.hash0[ADDR_WIDTH-1:0];
      end else if (state == bf_pkg::st_write && !pass) begin
         cur_addr <= ev_q.hash1[ADDR_WIDTH-1:0];  // switch to hash1
      end

      if (state == bf_pkg::st_wait && rd_vld) begin
         rec_q <= rd_data;
      end
   end

   assign update_go = (state == bf_pkg::st_update);

   bucket_update u_update (
      .clk       (clk),
      .rst_n     (rst_n),
      .update_go (update_go),
      .kind      (ev_q.kind),
      .rec_in    (rec_q),
      .rec_out   (rec_new)
   );

   // strobes straight from the state
   assign rd_req  = (state == bf_pkg::st_read);
   assign rd_addr = cur_addr;

   // write-back, rec_new is valid in st_write
   assign wr_req  = (state == bf_pkg::st_write);
   assign wr_addr = cur_addr;
   assign wr_data = rec_new;

endmodule

//--- src/bloom_filter_top.sv
module bloom_filter_top #(
   parameter int ADDR_WIDTH = 19,  // at most hash_width
   parameter int DEPTH_BITS = 3
) (
   input  logic                  clk,
   input  logic                  rst_n,

   // event input, ev_valid is lost while ev_full is high
   input  logic                  ev_valid,
   input  bf_pkg::bf_event_t     ev,
   output logic                  ev_full,

   // SRAM read
   output logic                  rd_req,
   output logic [ADDR_WIDTH-1:0] rd_addr,
   input  bf_pkg::record_t       rd_data,
   input  logic                  rd_vld,

   // SRAM write
   output logic                  wr_req,
   output logic [ADDR_WIDTH-1:0] wr_addr,
   output bf_pkg::record_t       wr_data
);

   bf_pkg::bf_event_t head_ev;
   logic              not_empty;
   logic              pop;

   event_queue #(
      .DEPTH_BITS (DEPTH_BITS)
   ) u_queue (
      .clk       (clk),
      .rst_n     (rst_n),
      .push      (ev_valid),
      .push_ev   (ev),
      .pop       (pop),
      .head_ev   (head_ev),
      .not_empty (not_empty),
      .full      (ev_full)
   );

   bucket_sequencer #(
      .ADDR_WIDTH (ADDR_WIDTH)
   ) u_seq (
      .clk       (clk),
      .rst_n     (rst_n),
      .head_ev   (head_ev),
      .not_empty (not_empty),
      .pop       (pop),
      .rd_req    (rd_req),
      .rd_addr   (rd_addr),
      .rd_data   (rd_data),
      .rd_vld    (rd_vld),
      .wr_req    (wr_req),
      .wr_addr   (wr_addr),
      .wr_data   (wr_data)
   );

endmodule

//--- verification/sram_model.sv
module sram_model #(
   parameter int ADDR_WIDTH = 5
) (
   input  logic                  clk,
   input  logic                  rst_n,

   // read port, answered after 1 to 4 cycles
   input  logic                  rd_req,
   input  logic [ADDR_WIDTH-1:0] rd_addr,
   output bf_pkg::record_t       rd_data,
   output logic                  rd_vld,

   // write port, takes effect at the clock edge
   input  logic                  wr_req,
   input  logic [ADDR_WIDTH-1:0] wr_addr,
   input  bf_pkg::record_t       wr_data,

   // backdoor load, only while the design is idle
   input  logic                  load_en,
   input  logic [ADDR_WIDTH-1:0] load_addr,
   input  bf_pkg::record_t       load_data
);

   localparam int words = 1 << ADDR_WIDTH;

   bf_pkg::record_t       mem [words];
   logic [ADDR_WIDTH-1:0] pend_addr;  // address of the open read
   int                    delay;      // cycles left, 0 when no read is open
   integer                lat_seed = 22;

   always @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < words; i++) begin
            mem[i] <= '0;  // all records start empty
         end
      end else if (load_en) begin
         mem[load_addr] <= load_data;
      end else if (wr_req) begin
         mem[wr_addr] <= wr_data;
      end
   end

   // read side runs on the falling edge, like all inputs of the design
   always @(negedge clk) begin
      if (!rst_n) begin
         delay   <= 0;
         rd_vld  <= 1'b0;
         rd_data <= '0;
      end else begin
         rd_vld <= 1'b0;
         if (delay == 1) begin
            rd_vld  <= 1'b1;
            rd_data <= mem[pend_addr];
            delay   <= 0;
         end else if (delay > 1) begin
            delay <= delay - 1;
         end
         if (rd_req && delay == 0) begin
            pend_addr <= rd_addr;
            delay     <= 1 + int'($unsigned($random(lat_seed)) % 4);
         end
      end
   end

endmodule

//--- verification/tb_bloom_filter.sv
module tb_bloom_filter;

   localparam int ADDR_WIDTH = 5;  // small so that hashes collide often
   localparam int DEPTH_BITS = 2;
   localparam int words      = 1 << ADDR_WIDTH;
   localparam int depth      = 1 << DEPTH_BITS;

   localparam int n_directed   = 3;
   localparam int n_sat        = 40;
   localparam int n_mixed      = 120;
   localparam int n_burst      = 200;
   localparam int n_events     = n_directed + n_sat + n_mixed + n_burst;
   localparam int limit_cycles = n_events * 20 + 200;

   logic                  clk;
   logic                  rst_n;
   logic                  ev_valid;
   bf_pkg::bf_event_t     ev;
   logic                  ev_full;
   logic                  rd_req;
   logic [ADDR_WIDTH-1:0] rd_addr;
   bf_pkg::record_t       rd_data;
   logic                  rd_vld;
   logic                  wr_req;
   logic [ADDR_WIDTH-1:0] wr_addr;
   bf_pkg::record_t       wr_data;
   logic                  load_en;
   logic [ADDR_WIDTH-1:0] load_addr;
   bf_pkg::record_t       load_data;

   integer                seed;
   bf_pkg::record_t       model_mem [words];  // expected SRAM contents
   logic [ADDR_WIDTH-1:0] exp_addr [$];       // expected writes in order
   bf_pkg::record_t       exp_data [$];
   int                    q_level;            // events waiting in the DUT FIFO
   int                    writes_seen;        // number of writes seen by the monitor
   logic                  saw_full;
   logic                  saw_sat;
   logic                  saw_zero_ack;
   logic                  saw_same;

   bloom_filter_top #(
      .ADDR_WIDTH (ADDR_WIDTH),
      .DEPTH_BITS (DEPTH_BITS)
   ) u_dut (
      .clk      (clk),
      .rst_n    (rst_n),
      .ev_valid (ev_valid),
      .ev       (ev),
      .ev_full  (ev_full),
      .rd_req   (rd_req),
      .rd_addr  (rd_addr),
      .rd_data  (rd_data),
      .rd_vld   (rd_vld),
      .wr_req   (wr_req),
      .wr_addr  (wr_addr),
      .wr_data  (wr_data)
   );

   sram_model #(
      .ADDR_WIDTH (ADDR_WIDTH)
   ) u_sram (
      .clk       (clk),
      .rst_n     (rst_n),
      .rd_req    (rd_req),
      .rd_addr   (rd_addr),
      .rd_data   (rd_data),
      .rd_vld    (rd_vld),
      .wr_req    (wr_req),
      .wr_addr   (wr_addr),
      .wr_data   (wr_data),
      .load_en   (load_en),
      .load_addr (load_addr),
      .load_data (load_data)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   task automatic stop_with_failure();
      $display("TEST RESULT: FAIL");
      $fatal(1, "simulation stopped on the first error");
   endtask

   task automatic report_failure(input string what);
      $display("%s", what);
      stop_with_failure();
   endtask

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] expected);
      if (got !== expected) begin
         $display("Mismatch at time %0t: %s is 0x%0h, expected 0x%0h",
                  $time, name, got, expected);
         stop_with_failure();
      end
   endtask

   // reference rule for one record where bucket i sits in nibble i
   function automatic bf_pkg::record_t model_update(input bf_pkg::event_kind_t kind,
                                                    input bf_pkg::record_t rec);
      bf_pkg::bucket_t nib [bf_pkg::num_buckets];
      bf_pkg::record_t res;
      int              idx;
      for (int i = 0; i < bf_pkg::num_buckets; i++) begin
         nib[i] = rec[i*bf_pkg::bucket_bits +: bf_pkg::bucket_bits];
      end
      if (kind == bf_pkg::ev_data) begin
         if (nib[11] != 4'hf) nib[11] = nib[11] + 4'h1;  // saturates at 15
      end else begin
         idx = bf_pkg::num_buckets - 1;
         while (idx >= 0 && nib[idx] == 4'h0) begin
            idx--;
         end
         if (idx >= 0) nib[idx] = nib[idx] - 4'h1;  // idx below 0 leaves the record as is
      end
      res = '0;
      for (int i = 0; i < bf_pkg::num_buckets; i++) begin
         res[i*bf_pkg::bucket_bits +: bf_pkg::bucket_bits] = nib[i];
      end
      return res;
   endfunction

   // both passes of an accepted event with hash0 first
   task automatic accept_event(input bf_pkg::bf_event_t e);
      logic [ADDR_WIDTH-1:0] addr [2];
      addr[0] = e.hash0[ADDR_WIDTH-1:0];
      addr[1] = e.hash1[ADDR_WIDTH-1:0];
      if (addr[0] == addr[1]) saw_same = 1'b1;
      for (int p = 0; p < 2; p++) begin
         if (e.kind == bf_pkg::ev_data && model_mem[addr[p]][47:44] == 4'hf) saw_sat = 1'b1;
         if (e.kind == bf_pkg::ev_ack && model_mem[addr[p]] == '0) saw_zero_ack = 1'b1;
         model_mem[addr[p]] = model_update(e.kind, model_mem[addr[p]]);
         exp_addr.push_back(addr[p]);
         exp_data.push_back(model_mem[addr[p]]);
      end
   endtask

   function automatic bf_pkg::bf_event_t random_event(input int ack_pct, input int span);
      bf_pkg::bf_event_t e;
      e.kind  = ($unsigned($random(seed)) % 100 < ack_pct) ? bf_pkg::ev_ack : bf_pkg::ev_data;
      e.hash0 = bf_pkg::hash_t'($random(seed));
      e.hash1 = bf_pkg::hash_t'($random(seed));
      e.hash0[ADDR_WIDTH-1:0] = ADDR_WIDTH'($unsigned($random(seed)) % span);
      e.hash1[ADDR_WIDTH-1:0] = ADDR_WIDTH'($unsigned($random(seed)) % span);
      return e;
   endfunction

   // drives on the next free falling edge so back-to-back calls make a burst
   task automatic send_event(input bf_pkg::bf_event_t e);
      @(negedge clk);
      while (ev_full) begin
         ev_valid = 1'b0;
         saw_full = 1'b1;
         @(negedge clk);
      end
      ev_valid = 1'b1;
      ev       = e;
      accept_event(e);
      @(posedge clk);
      q_level++;  // pushed at this edge
   endtask

   task automatic drain_events();
      @(negedge clk);
      ev_valid = 1'b0;
      while (exp_addr.size() != 0) begin
         @(negedge clk);
      end
      repeat (3) @(negedge clk);  // back to idle
   endtask

   // sparse random records so an ack has to search downward
   task automatic preload_records(input int lo, input int hi);
      bf_pkg::record_t rec;
      logic [31:0]     r;
      for (int a = lo; a <= hi; a++) begin
         rec = '0;
         for (int b = 0; b < bf_pkg::num_buckets; b++) begin
            r = $random(seed);
            if (r[1:0] == 2'b00) rec[b*bf_pkg::bucket_bits +: bf_pkg::bucket_bits] = r[7:4];
         end
         @(negedge clk);
         load_en   = 1'b1;
         load_addr = ADDR_WIDTH'(a);
         load_data = rec;
         model_mem[a] = rec;
      end
      @(negedge clk);
      load_en = 1'b0;
   endtask

   // watchdog
   initial begin
      repeat (limit_cycles) @(posedge clk);
      $display("timeout: the run did not finish within %0d cycles", limit_cycles);
      stop_with_failure();
   end

   // read and write monitor
   always @(negedge clk) begin
      if (rst_n) begin
         if (rd_req) begin
            if (exp_addr.size() == 0) begin
               report_failure("read request seen with no event pending");
            end else begin
               check_value("rd_addr", 64'(rd_addr), 64'(exp_addr[0]));
               // first read of an event follows the pop by one cycle
               if (writes_seen % 2 == 0) begin
                  q_level--;
               end
            end
         end
         check_value("ev_full", 64'(ev_full), 64'(q_level == depth));
         if (wr_req) begin
            if (exp_addr.size() == 0) begin
               report_failure("write seen with no event pending");
            end else begin
               check_value("wr_addr", 64'(wr_addr), 64'(exp_addr[0]));
               check_value("wr_data", 64'(wr_data), 64'(exp_data[0]));
               void'(exp_addr.pop_front());
               void'(exp_data.pop_front());
               writes_seen++;
            end
         end
      end
   end

   initial begin
      bf_pkg::bf_event_t e;
      seed         = 22;
      rst_n        = 1'b0;
      ev_valid     = 1'b0;
      ev           = '0;
      load_en      = 1'b0;
      load_addr    = '0;
      load_data    = '0;
      q_level      = 0;
      writes_seen  = 0;
      saw_full     = 1'b0;
      saw_sat      = 1'b0;
      saw_zero_ack = 1'b0;
      saw_same     = 1'b0;
      for (int a = 0; a < words; a++) begin
         model_mem[a] = '0;
      end

      repeat (4) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);
      check_value("rd_req", 64'(rd_req), 64'd0);
      check_value("wr_req", 64'(wr_req), 64'd0);
      check_value("ev_full", 64'(ev_full), 64'd0);

      // ack on empty records 3 and 7
      e.kind  = bf_pkg::ev_ack;
      e.hash0 = 19'h00003;
      e.hash1 = 19'h12347;
      send_event(e);
      drain_events();

      // both hashes on record 5 with data then ack
      e.kind  = bf_pkg::ev_data;
      e.hash0 = 19'h00045;
      e.hash1 = 19'h7ffe5;
      send_event(e);
      drain_events();
      e.kind = bf_pkg::ev_ack;
      send_event(e);
      drain_events();

      for (int i = 0; i < n_sat; i++) begin
         send_event(random_event(0, 4));  // few addresses so bucket 11 reaches 15
      end
      drain_events();

      preload_records(words / 2, words - 1);
      for (int i = 0; i < n_mixed; i++) begin
         send_event(random_event(50, words));
      end
      drain_events();

      for (int i = 0; i < n_burst; i++) begin
         send_event(random_event(30, words));
      end
      drain_events();

      for (int a = 0; a < words; a++) begin
         check_value($sformatf("sram record %0d", a), 64'(u_sram.mem[a]), 64'(model_mem[a]));
      end

      if (!(saw_full && saw_sat && saw_zero_ack && saw_same)) begin
         report_failure(
            $sformatf("case not reached: full %0b, saturation %0b, zero ack %0b, same %0b",
                      saw_full, saw_sat, saw_zero_ack, saw_same));
      end else begin
         $display("TEST RESULT: PASS");
         $finish;
      end
   end

endmodule

//--- sim.f
src/bf_pkg.sv
src/event_queue.sv
src/bucket_update.sv
src/bucket_sequencer.sv
src/bloom_filter_top.sv
verification/sram_model.sv
verification/tb_bloom_filter.sv

//--- run.sh
#!/bin/sh
# compile and run the bloom filter testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_bloom_filter -Mdir obj_dir -f sim.f
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

output=$(./obj_dir/Vtb_bloom_filter 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$output" | grep -qx "TEST RESULT: PASS"; then
   exit 0
else
   echo "pass line not found"
   exit 1
fi
